/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // Word width and memory geometry
    localparam int XLen         = 32;
    localparam int ImemAddrBits = 6;                 // 64 instruction words
    localparam int DmemAddrBits = 6;                 // 64 data words
    localparam int ImemDepth    = 1 << ImemAddrBits;
    localparam int DmemDepth    = 1 << DmemAddrBits;

    // Major opcodes
    localparam logic [6:0] OpRType = 7'b0110011;     // Register-register ALU
    localparam logic [6:0] OpIType = 7'b0010011;     // Immediate ALU
    localparam logic [6:0] OpLoad  = 7'b0000011;     // LW
    localparam logic [6:0] OpStore = 7'b0100011;     // SW

    // funct3 codes for the ALU groups
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Sll    = 3'b001;
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Sltu   = 3'b011;
    localparam logic [2:0] F3Xor    = 3'b100;
    localparam logic [2:0] F3SrlSra = 3'b101;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;
    localparam logic [2:0] F3Word   = 3'b010;       // Width code of LW and SW

    localparam logic [6:0] Funct7Alt = 7'b0100000;  // SUB, SRA, SRAI

    // Internal ALU operation codes
    localparam logic [3:0] AluAdd  = 4'd0;
    localparam logic [3:0] AluSub  = 4'd1;
    localparam logic [3:0] AluSll  = 4'd2;
    localparam logic [3:0] AluSlt  = 4'd3;
    localparam logic [3:0] AluSltu = 4'd4;
    localparam logic [3:0] AluXor  = 4'd5;
    localparam logic [3:0] AluSrl  = 4'd6;
    localparam logic [3:0] AluSra  = 4'd7;
    localparam logic [3:0] AluOr   = 4'd8;
    localparam logic [3:0] AluAnd  = 4'd9;

    // One instruction word seen in the R and in the I layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
    } instWord_u;

endpackage

`default_nettype wire

/* design/instMem.sv */
`default_nettype none

module instMem (
    input  wire logic                             CLK,
    input  wire logic                             loadEn,
    input  wire logic [cpuPkg::ImemAddrBits-1:0]  loadAddr,
    input  wire logic [cpuPkg::XLen-1:0]          loadData,
    input  wire logic [cpuPkg::ImemAddrBits-1:0]  readAddr,
    output      logic [cpuPkg::XLen-1:0]          readData
);

    // Program storage, filled through the load port
    logic [cpuPkg::XLen-1:0] mem [cpuPkg::ImemDepth];

    always_ff @(posedge CLK) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;      // Program load
        end
    end

    // Fetch happens in the same cycle as the address
    assign readData = mem[readAddr];

endmodule

`default_nettype wire

/* design/registerFile.sv */
`default_nettype none

module registerFile (
    input  wire logic                     CLK,
    input  wire logic                     RST,
    input  wire logic [4:0]               rs1,
    input  wire logic [4:0]               rs2,
    input  wire logic [4:0]               rd,
    input  wire logic [cpuPkg::XLen-1:0]  wrData,
    input  wire logic                     we,
    output      logic [cpuPkg::XLen-1:0]  rdData1,
    output      logic [cpuPkg::XLen-1:0]  rdData2
);

    // x1..x31 only, x0 has no storage
    logic [cpuPkg::XLen-1:0] regs [1:31];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wrData;                  // Writes to x0 dropped
        end
    end

    // Reads see the value before this cycle's write
    assign rdData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* design/dataMem.sv */
`default_nettype none

module dataMem (
    input  wire logic                     CLK,
    input  wire logic                     we,
    input  wire logic [cpuPkg::XLen-1:0]  addr,
    input  wire logic [cpuPkg::XLen-1:0]  wrData,
    output      logic [cpuPkg::XLen-1:0]  readData
);

    logic [cpuPkg::XLen-1:0]         mem [cpuPkg::DmemDepth];
    logic [cpuPkg::DmemAddrBits-1:0] wordAddr;

    // Byte offset dropped, upper bits ignored so the space wraps
    assign wordAddr = addr[cpuPkg::DmemAddrBits+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordAddr] <= wrData;    // SW
        end
    end

    assign readData = mem[wordAddr];    // LW data, same cycle

endmodule

`default_nettype wire

/* design/alu.sv */
`default_nettype none

module alu (
    input  wire logic [3:0]               aluOp,
    input  wire logic [cpuPkg::XLen-1:0]  opA,
    input  wire logic [cpuPkg::XLen-1:0]  opB,
    output      logic [cpuPkg::XLen-1:0]  result
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = opB[4:0];                       // Low five bits only
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        unique case (aluOp)
            cpuPkg::AluAdd: begin
                result = opA + opB;
            end
            cpuPkg::AluSub: begin
                result = opA - opB;
            end
            cpuPkg::AluSll: begin
                result = opA << shamt;
            end
            cpuPkg::AluSlt: begin
                result = {{(cpuPkg::XLen-1){1'b0}}, ltSigned};
            end
            cpuPkg::AluSltu: begin
                result = {{(cpuPkg::XLen-1){1'b0}}, ltUnsigned};
            end
            cpuPkg::AluXor: begin
                result = opA ^ opB;
            end
            cpuPkg::AluSrl: begin
                result = opA >> shamt;                  // Zero fill
            end
            cpuPkg::AluSra: begin
                result = $unsigned($signed(opA) >>> shamt); // Sign fill
            end
            cpuPkg::AluOr: begin
                result = opA | opB;
            end
            cpuPkg::AluAnd: begin
                result = opA & opB;
            end
            default: begin
                result = '0;                            // Unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/controlUnit.sv */
`default_nettype none

module controlUnit (
    input  wire cpuPkg::instWord_u        instr,
    output      logic [4:0]               rs1,
    output      logic [4:0]               rs2,
    output      logic [4:0]               rd,
    output      logic [3:0]               aluOp,
    output      logic                     useImm,
    output      logic                     regWe,
    output      logic                     memToReg,
    output      logic                     memWe,
    output      logic [cpuPkg::XLen-1:0]  imm
);

    logic                    isAlt;
    logic                    rdNonZero;
    logic [cpuPkg::XLen-1:0] immI;
    logic [cpuPkg::XLen-1:0] immS;

    // Shared funct3 mapping of the R and I groups
    function automatic logic [3:0] funct3ToOp(input logic [2:0] f3, input logic alt,
                                              input logic subAllowed);
        logic [3:0] op;
        unique case (f3)
            cpuPkg::F3AddSub: op = (alt && subAllowed) ? cpuPkg::AluSub : cpuPkg::AluAdd;
            cpuPkg::F3Sll:    op = cpuPkg::AluSll;
            cpuPkg::F3Slt:    op = cpuPkg::AluSlt;
            cpuPkg::F3Sltu:   op = cpuPkg::AluSltu;
            cpuPkg::F3Xor:    op = cpuPkg::AluXor;
            cpuPkg::F3SrlSra: op = alt ? cpuPkg::AluSra : cpuPkg::AluSrl;
            cpuPkg::F3Or:     op = cpuPkg::AluOr;
            default:          op = cpuPkg::AluAnd;
        endcase
        return op;
    endfunction

    assign rs1 = instr.rType.rs1;
    assign rs2 = instr.rType.rs2;
    assign rd  = instr.rType.rd;

    assign isAlt     = (instr.rType.funct7 == cpuPkg::Funct7Alt); // Also SRAI's imm[11:5]
    assign rdNonZero = (instr.rType.rd != 5'd0);

    assign immI = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
    // S immediate sits in the funct7 and rd slots
    assign immS = {{20{instr.rType.funct7[6]}}, instr.rType.funct7, instr.rType.rd};

    always_comb begin
        aluOp    = cpuPkg::AluAdd;
        useImm   = 1'b0;
        regWe    = 1'b0;
        memToReg = 1'b0;
        memWe    = 1'b0;
        imm      = immI;
        unique case (instr.rType.opcode)
            cpuPkg::OpRType: begin
                aluOp = funct3ToOp(instr.rType.funct3, isAlt, 1'b1);
                regWe = rdNonZero;
            end
            cpuPkg::OpIType: begin
                aluOp  = funct3ToOp(instr.iType.funct3, isAlt, 1'b0); // No SUBI
                useImm = 1'b1;
                regWe  = rdNonZero;
            end
            cpuPkg::OpLoad: begin
                useImm   = 1'b1;
                regWe    = rdNonZero && (instr.iType.funct3 == cpuPkg::F3Word);
                memToReg = 1'b1;
            end
            cpuPkg::OpStore: begin
                useImm = 1'b1;
                imm    = immS;
                memWe  = (instr.rType.funct3 == cpuPkg::F3Word);
            end
            default: begin
            end                                 // Unknown opcode is a no-op
        endcase
    end

endmodule

`default_nettype wire

/* design/singleCpu.sv */
`default_nettype none

module singleCpu (
    input  wire logic                             CLK,
    input  wire logic                             RST,
    input  wire logic                             loadEn,
    input  wire logic [cpuPkg::ImemAddrBits-1:0]  loadAddr,
    input  wire logic [cpuPkg::XLen-1:0]          loadData,
    output      logic [cpuPkg::XLen-1:0]          pc,
    output      logic [cpuPkg::XLen-1:0]          instr,
    output      logic                             wbEn,
    output      logic [4:0]                       wbReg,
    output      logic [cpuPkg::XLen-1:0]          wbData,
    output      logic                             memWe,
    output      logic [cpuPkg::XLen-1:0]          memAddr,
    output      logic [cpuPkg::XLen-1:0]          memData
);

    logic [cpuPkg::ImemAddrBits-1:0] pcWord;    // Word index, wraps with the memory
    cpuPkg::instWord_u               fetchWord;

    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [4:0]              rd;
    logic [3:0]              aluOp;
    logic                    useImm;
    logic                    regWe;
    logic                    memToReg;
    logic                    storeEn;
    logic [cpuPkg::XLen-1:0] imm;
    logic [cpuPkg::XLen-1:0] rdData1;
    logic [cpuPkg::XLen-1:0] rdData2;
    logic [cpuPkg::XLen-1:0] opB;
    logic [cpuPkg::XLen-1:0] result;
    logic [cpuPkg::XLen-1:0] loadValue;
    logic [cpuPkg::XLen-1:0] wbValue;
    logic                    regWeGated;
    logic                    memWeGated;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pcWord <= '0;
        end else begin
            pcWord <= pcWord + 1'b1;            // One instruction per clock
        end
    end

    assign pc = {{(cpuPkg::XLen-cpuPkg::ImemAddrBits-2){1'b0}}, pcWord, 2'b00};

    instMem i_instMem (
        .CLK      (CLK),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .readAddr (pcWord),
        .readData (fetchWord)
    );

    controlUnit i_controlUnit (
        .instr    (fetchWord),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .aluOp    (aluOp),
        .useImm   (useImm),
        .regWe    (regWe),
        .memToReg (memToReg),
        .memWe    (storeEn),
        .imm      (imm)
    );

    // No retirement while the core is held in reset
    assign regWeGated = regWe && !RST;
    assign memWeGated = storeEn && !RST;

    registerFile i_registerFile (
        .CLK     (CLK),
        .RST     (RST),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wrData  (wbValue),
        .we      (regWeGated),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    assign opB = useImm ? imm : rdData2;        // Second ALU operand

    alu i_alu (
        .aluOp  (aluOp),
        .opA    (rdData1),
        .opB    (opB),
        .result (result)
    );

    dataMem i_dataMem (
        .CLK      (CLK),
        .we       (memWeGated),
        .addr     (result),                     // Effective address
        .wrData   (rdData2),
        .readData (loadValue)
    );

    assign wbValue = memToReg ? loadValue : result;

    // Trace of what retires on the next edge
    assign instr   = fetchWord;
    assign wbEn    = regWeGated;
    assign wbReg   = rd;
    assign wbData  = wbValue;
    assign memWe   = memWeGated;
    assign memAddr = result;
    assign memData = rdData2;

endmodule

`default_nettype wire

/* dv/singleCpu_chk.sv */
`default_nettype none

module singleCpuChk (
    input wire logic                     CLK,
    input wire logic                     RST,
    input wire logic [cpuPkg::XLen-1:0]  pc,
    input wire logic                     wbEn,
    input wire logic [4:0]               wbReg
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [cpuPkg::XLen-1:0] PcSpan = cpuPkg::ImemDepth * 4;   // Bytes of imem

    // Fetch stays at word 0 while reset is held
    pcHeldInReset: assert property (@(posedge CLK) (RST && $past(RST)) |-> (pc == '0))
        else $error("Program counter not held at zero while reset is held");

    noZeroWrite: assert property (@(posedge CLK) wbEn |-> (wbReg != 5'd0))
        else $error("Register write to x0 shown on the trace");

    // Sequential fetch, wraps at the end of instruction memory
    pcStep: assert property (@(posedge CLK) (!RST && $past(!RST)) |->
                             (pc == ($past(pc) + 32'd4) % PcSpan))
        else $error("Program counter did not advance by four");

endmodule

bind singleCpu singleCpuChk i_singleCpuChk (
    .CLK   (CLK),
    .RST   (RST),
    .pc    (pc),
    .wbEn  (wbEn),
    .wbReg (wbReg)
);

`default_nettype wire

/* dv/tbSingleCpu.sv */
`default_nettype none

module tbSingleCpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MaxProgLen    = 48;                   // Longest program below is 33
    localparam int NumTests      = 5;
    localparam int ResetCycles   = 4;
    localparam int CyclesPerTest = 2 * MaxProgLen + ResetCycles + 4;  // Load, reset, run
    localparam int WatchdogNs    = NumTests * CyclesPerTest * 8 + 400;

    logic                              CLK;
    logic                              RST;
    logic                              loadEn;
    logic [cpuPkg::ImemAddrBits-1:0]   loadAddr;
    logic [cpuPkg::XLen-1:0]           loadData;
    logic [cpuPkg::XLen-1:0]           pc;
    logic [cpuPkg::XLen-1:0]           instr;
    logic                              wbEn;
    logic [4:0]                        wbReg;
    logic [cpuPkg::XLen-1:0]           wbData;
    logic                              memWe;
    logic [cpuPkg::XLen-1:0]           memAddr;
    logic [cpuPkg::XLen-1:0]           memData;

    logic [31:0] prog [$];                           // Program of the current test
    logic [31:0] mRegs [32];                         // Model register file
    logic [31:0] mMem [cpuPkg::DmemDepth];           // Model data memory, kept across tests
    logic [31:0] lfsr = 32'h2aed;
    int          wordErrs;
    int          regErrs;
    int          bitErrs;

    singleCpu i_singleCpu (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, cpuPkg::OpRType};
    endfunction

    function automatic logic [31:0] encI(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, cpuPkg::OpIType};
    endfunction

    function automatic logic [31:0] encLw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, cpuPkg::F3Word, rd, cpuPkg::OpLoad};
    endfunction

    function automatic logic [31:0] encSw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, cpuPkg::F3Word, imm[4:0], cpuPkg::OpStore};
    endfunction

    // ISA result of one R or I ALU instruction
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic isReg, input logic [31:0] a, b);
        logic [31:0] res;
        case (f3)
            3'd0: res = (alt && isReg) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic checkWord(input string name, input logic [cpuPkg::XLen-1:0] exp, act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            wordErrs++;
        end
    endtask

    task automatic checkReg(input string name, input logic [4:0] exp, act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
            regErrs++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
            bitErrs++;
        end
    endtask

    // Load prog under reset, then check every retirement against the model
    task automatic runProgram(input string name);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic [4:0]  rd;
        logic        expWb;
        logic        expSt;
        @(posedge CLK);
        RST <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge CLK);
            loadEn   <= 1'b1;
            loadAddr <= cpuPkg::ImemAddrBits'(i);
            loadData <= prog[i];
        end
        @(posedge CLK);
        loadEn <= 1'b0;
        repeat (ResetCycles) @(posedge CLK);
        @(negedge CLK);
        checkWord({name, " reset pc"}, '0, pc);
        checkBit({name, " reset wbEn"}, 1'b0, wbEn);
        checkBit({name, " reset memWe"}, 1'b0, memWe);
        foreach (mRegs[r]) begin
            mRegs[r] = '0;
        end
        @(posedge CLK);
        RST <= 1'b0;
        for (int k = 0; k < prog.size(); k++) begin
            w     = prog[k];
            rd    = w[11:7];
            a     = mRegs[w[19:15]];
            b     = mRegs[w[24:20]];
            addr  = a + {{20{w[31]}}, w[31:25], w[11:7]};   // Store address
            val   = '0;
            expWb = 1'b0;
            expSt = 1'b0;
            case (w[6:0])
                cpuPkg::OpRType: begin
                    val   = refAlu(w[14:12], w[31:25] == 7'h20, 1'b1, a, b);
                    expWb = (rd != 5'd0);
                end
                cpuPkg::OpIType: begin
                    val   = refAlu(w[14:12], w[31:25] == 7'h20, 1'b0, a, {{20{w[31]}}, w[31:20]});
                    expWb = (rd != 5'd0);
                end
                cpuPkg::OpLoad: begin
                    val   = mMem[8'(a + {{20{w[31]}}, w[31:20]}) >> 2];
                    expWb = (rd != 5'd0);
                end
                cpuPkg::OpStore: expSt = 1'b1;
                default: expWb = 1'b0;                      // No-op
            endcase
            @(negedge CLK);
            checkWord({name, " pc"}, 32'(k * 4), pc);
            checkWord({name, " instr"}, w, instr);
            checkBit({name, " wbEn"}, expWb, wbEn);
            checkBit({name, " memWe"}, expSt, memWe);
            if (expWb) begin
                checkReg({name, " wbReg"}, rd, wbReg);
                checkWord({name, " wbData"}, val, wbData);
                mRegs[rd] = val;
            end
            if (expSt) begin
                checkWord({name, " memAddr"}, addr, memAddr);
                checkWord({name, " memData"}, b, memData);
                mMem[addr[cpuPkg::DmemAddrBits+1:2]] = b;
            end
        end
    endtask

    task automatic resetAndFetch();
        prog.delete();
        for (int i = 0; i < 8; i++) begin
            prog.push_back(encI(cpuPkg::F3AddSub, 5'(i + 1), 5'd0, 12'(i * 3 - 9)));
        end
        runProgram("resetAndFetch");
    endtask

    task automatic immediateOps();
        logic [11:0] imm;
        prog.delete();
        for (int r = 1; r <= 4; r++) begin
            prog.push_back(encI(cpuPkg::F3AddSub, 5'(r), 5'd0, 12'(randBits(12))));
        end
        for (int rep = 0; rep < 2; rep++) begin
            for (int f = 0; f < 8; f++) begin
                imm = (f == 1 || f == 5) ? {7'h00, 5'(randBits(5))} : 12'(randBits(12));
                prog.push_back(encI(3'(f), 5'(randBits(5)), 5'(randBits(2) + 1), imm));
            end
            imm = {7'h20, 5'(randBits(5))};                    // SRAI
            prog.push_back(encI(cpuPkg::F3SrlSra, 5'(randBits(5)), 5'(randBits(2) + 1), imm));
        end
        runProgram("immediateOps");
    endtask

    task automatic registerOps();
        prog.delete();
        for (int r = 1; r <= 6; r++) begin
            prog.push_back(encI(cpuPkg::F3AddSub, 5'(r), 5'd0, 12'(randBits(12))));
            prog.push_back(encI(cpuPkg::F3Sll, 5'(r), 5'(r), 12'(randBits(4) + 8)));
        end
        prog.push_back(encI(cpuPkg::F3AddSub, 5'd7, 5'd0, 12'h800));  // Sign bit set
        for (int rep = 0; rep < 2; rep++) begin
            for (int f = 0; f < 8; f++) begin
                prog.push_back(encR(7'h00, 3'(f), 5'(randBits(4) + 16), 5'(randBits(3)),
                                    5'(randBits(3))));
                if (f == 0 || f == 5) begin
                    prog.push_back(encR(cpuPkg::Funct7Alt, 3'(f), 5'(randBits(4) + 16),
                                        5'(randBits(3)), 5'(randBits(3))));
                end
            end
        end
        runProgram("registerOps");
    endtask

    task automatic storeLoad();
        int offs [4] = '{-8, 0, 12, 40};
        prog.delete();
        for (int r = 1; r <= 4; r++) begin
            prog.push_back(encI(cpuPkg::F3AddSub, 5'(r), 5'd0, 12'(randBits(12))));
            prog.push_back(encI(cpuPkg::F3Sll, 5'(r), 5'(r), 12'(randBits(5))));
        end
        prog.push_back(encI(cpuPkg::F3AddSub, 5'd5, 5'd0, 12'd64));   // Base address
        for (int i = 0; i < 4; i++) begin
            prog.push_back(encSw(5'(i + 1), 5'd5, 12'(offs[i])));
        end
        for (int i = 0; i < 4; i++) begin
            prog.push_back(encLw(5'(i + 10), 5'd5, 12'(offs[i])));
        end
        runProgram("storeLoad");
    endtask

    task automatic zeroRegAndNop();
        prog.delete();
        prog.push_back(encI(cpuPkg::F3AddSub, 5'd1, 5'd0, 12'(randBits(12) | 1)));
        prog.push_back(encI(cpuPkg::F3AddSub, 5'd2, 5'd0, 12'(randBits(12))));
        prog.push_back(encI(cpuPkg::F3AddSub, 5'd0, 5'd1, 12'd5));
        prog.push_back(encR(7'h00, cpuPkg::F3AddSub, 5'd0, 5'd1, 5'd2));
        prog.push_back({20'(randBits(20)), 5'd3, 7'h7f});      // Unknown opcode, rd x3
        prog.push_back(encR(7'h00, cpuPkg::F3AddSub, 5'd5, 5'd3, 5'd0));
        prog.push_back(encR(7'h00, cpuPkg::F3AddSub, 5'd3, 5'd0, 5'd1));
        prog.push_back(encR(7'h00, cpuPkg::F3AddSub, 5'd4, 5'd2, 5'd0));
        runProgram("zeroRegAndNop");
    endtask

    initial begin
        RST      = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        wordErrs = 0;
        regErrs  = 0;
        bitErrs  = 0;
        resetAndFetch();
        immediateOps();
        registerOps();
        storeLoad();
        zeroRegAndNop();
        @(posedge CLK);
        $display("Errors: %0d word, %0d register index, %0d enable", wordErrs, regErrs, bitErrs);
        if (wordErrs + regErrs + bitErrs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs * 1ns);
        $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
design/cpuPkg.sv
design/instMem.sv
design/registerFile.sv
design/dataMem.sv
design/alu.sv
design/controlUnit.sv
design/singleCpu.sv
dv/singleCpu_chk.sv
dv/tbSingleCpu.sv

/* run.sh */
#!/bin/sh
# Build and run the singleCpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbSingleCpu \
    -f all.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
